//--- files.f
+incdir+verif
src/kd_pkg.sv
src/kd_internal_node.sv
src/kd_node_tree.sv
src/kd_wb_port.sv
src/kd_search_top.sv
verif/tb_kd_search.sv

//--- src/kd_internal_node.sv
// kd tree internal node
`default_nettype none

module kd_internal_node (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wen_i,      // write strobe from the tree decoder
    input  kd_pkg::node_word_t            wdata_i,
    input  logic [kd_pkg::KD_PATCH_W-1:0] patch_a_i,  // patch at this node's level, lane a
    input  logic [kd_pkg::KD_PATCH_W-1:0] patch_b_i,
    input  logic                          valid_a_i,  // lane a patch sits on this node
    input  logic                          valid_b_i,
    output logic                          left_a_o,
    output logic                          right_a_o,
    output logic                          left_b_o,
    output logic                          right_b_o,
    output kd_pkg::node_word_t            rdata_o     // stored word, for bus readback
);
    import kd_pkg::*;

    node_word_t           word_q;   // dim + median
    logic [KD_COMP_W-1:0] comp_a;   // selected component, lane a
    logic [KD_COMP_W-1:0] comp_b;
    logic                 below_a;  // comp < median
    logic                 below_b;

    // pick the component named by dim
    // out-of-range dims fall back to component 0
    function automatic logic [KD_COMP_W-1:0] sel_comp(
        input logic [KD_PATCH_W-1:0] patch,
        input logic [KD_COMP_W-1:0]  dim
    );
        logic [KD_COMP_W-1:0] comp;
        comp = patch[KD_COMP_W-1:0];
        for (int c = 1; c < KD_COMPS; c++) begin
            if (dim == KD_COMP_W'(c)) begin
                comp = patch[c*KD_COMP_W +: KD_COMP_W];
            end
        end
        return comp;
    endfunction

    // node storage, zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (wen_i) begin
            word_q <= wdata_i;  // visible the cycle after wen
        end
    end

    assign comp_a  = sel_comp(patch_a_i, word_q.tree.dim);
    assign comp_b  = sel_comp(patch_b_i, word_q.tree.dim);
    assign below_a = comp_a < word_q.tree.median;  // unsigned compare
    assign below_b = comp_b < word_q.tree.median;

    // route the valid to one child only
    assign left_a_o  = valid_a_i & below_a;
    assign right_a_o = valid_a_i & ~below_a;  // ties go right
    assign left_b_o  = valid_b_i & below_b;
    assign right_b_o = valid_b_i & ~below_b;

    assign rdata_o = word_q;

endmodule

`default_nettype wire

//--- src/kd_node_tree.sv
// kd tree node array and search pipeline
`default_nettype none

module kd_node_tree #(
    parameter int TREE_DEPTH = 6  // 3..6
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_mode_i,     // bus owns node writes
    input  logic                            load_en_i,      // host in load phase
    input  logic                            sender_en_i,
    input  kd_pkg::node_word_t              sender_data_i,
    input  logic                            wb_wen_i,       // commit pulse from bus port
    input  logic [kd_pkg::KD_MAX_DEPTH-1:0] wb_node_adr_i,
    input  kd_pkg::node_word_t              wb_wdata_i,
    output kd_pkg::node_word_t              wb_rdata_o,     // combinational readback
    input  logic                            patch_a_valid_i,
    input  logic [kd_pkg::KD_PATCH_W-1:0]   patch_a_i,
    input  logic                            patch_b_valid_i,
    input  logic [kd_pkg::KD_PATCH_W-1:0]   patch_b_i,
    output logic                            leaf_a_valid_o,
    output logic [kd_pkg::KD_MAX_DEPTH-1:0] leaf_a_idx_o,
    output logic                            leaf_b_valid_o,
    output logic [kd_pkg::KD_MAX_DEPTH-1:0] leaf_b_idx_o
);
    import kd_pkg::*;

    localparam int NODES  = 2**TREE_DEPTH - 1;
    localparam int LEAVES = 2**TREE_DEPTH;

    // write side
    logic [KD_MAX_DEPTH-1:0] wptr_q;    // stream pointer, level order
    logic                    stream_wen;
    logic                    wr_any;
    logic [KD_MAX_DEPTH-1:0] wr_adr;
    node_word_t              wr_data;
    logic [NODES-1:0]        node_wen;  // one-hot
    node_word_t              node_rdata [NODES];

    // search side
    // valid bits in heap order, bit n = node n, bits NODES.. = leaves
    // bit 0 is the registered input valid
    wire  [2*NODES:0]        vld_a_d;
    wire  [2*NODES:0]        vld_b_d;
    logic [2*NODES:0]        vld_a_q;
    logic [2*NODES:0]        vld_b_q;
    logic [KD_PATCH_W-1:0]   patch_a_q [TREE_DEPTH];  // one per level
    logic [KD_PATCH_W-1:0]   patch_b_q [TREE_DEPTH];
    logic [LEAVES-1:0]       leaves_a;
    logic [LEAVES-1:0]       leaves_b;

    // one-hot leaf to index
    // heap order makes the position equal to the path, MSB = root branch
    function automatic logic [KD_MAX_DEPTH-1:0] leaf_enc(input logic [LEAVES-1:0] leaves);
        logic [KD_MAX_DEPTH-1:0] idx;
        idx = '0;
        for (int k = 0; k < LEAVES; k++) begin
            if (leaves[k]) begin
                idx = idx | KD_MAX_DEPTH'(k);
            end
        end
        return idx;
    endfunction

    // stream load
    assign stream_wen = load_en_i & sender_en_i & ~cfg_mode_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr_q <= '0;
        end else if (stream_wen) begin
            wptr_q <= wptr_q + 1'b1;  // next node in level order
        end
    end

    // bus or stream picks the target
    assign wr_any  = stream_wen | (cfg_mode_i & wb_wen_i);
    assign wr_adr  = cfg_mode_i ? wb_node_adr_i : wptr_q;
    assign wr_data = cfg_mode_i ? wb_wdata_i : sender_data_i;

    // address decoder
    always_comb begin
        node_wen = '0;
        for (int n = 0; n < NODES; n++) begin
            if (wr_any && wr_adr == KD_MAX_DEPTH'(n)) begin
                node_wen[n] = 1'b1;
            end
        end
    end

    // readback, addresses past the last node read zero
    always_comb begin
        wb_rdata_o = '0;
        if (wb_node_adr_i < NODES) begin
            wb_rdata_o = node_rdata[wb_node_adr_i];
        end
    end

    // stage 0 takes the raw lane valids
    assign vld_a_d[0] = patch_a_valid_i;
    assign vld_b_d[0] = patch_b_valid_i;

    // node n drives children 2n+1 / 2n+2 of the next stage
    for (genvar l = 0; l < TREE_DEPTH; l++) begin : g_level
        for (genvar j = 0; j < 2**l; j++) begin : g_node
            localparam int N = 2**l - 1 + j;  // heap index

            kd_internal_node i_node (
                .clk       (clk),
                .rst_n     (rst_n),
                .wen_i     (node_wen[N]),
                .wdata_i   (wr_data),
                .patch_a_i (patch_a_q[l]),
                .patch_b_i (patch_b_q[l]),
                .valid_a_i (vld_a_q[N]),
                .valid_b_i (vld_b_q[N]),
                .left_a_o  (vld_a_d[2*N+1]),
                .right_a_o (vld_a_d[2*N+2]),
                .left_b_o  (vld_b_d[2*N+1]),
                .right_b_o (vld_b_d[2*N+2]),
                .rdata_o   (node_rdata[N])
            );
        end
    end

    // valid pipeline, every level registered at once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_a_q <= '0;
            vld_b_q <= '0;
        end else begin
            vld_a_q <= vld_a_d;
            vld_b_q <= vld_b_d;
        end
    end

    // patch pipeline, payload only
    always_ff @(posedge clk) begin
        patch_a_q[0] <= patch_a_i;
        patch_b_q[0] <= patch_b_i;
        for (int l = 1; l < TREE_DEPTH; l++) begin
            patch_a_q[l] <= patch_a_q[l-1];
            patch_b_q[l] <= patch_b_q[l-1];
        end
    end

    // last stage, at most one leaf set per lane
    assign leaves_a = vld_a_q[2*NODES:NODES];
    assign leaves_b = vld_b_q[2*NODES:NODES];

    assign leaf_a_valid_o = |leaves_a;
    assign leaf_b_valid_o = |leaves_b;
    assign leaf_a_idx_o   = leaf_enc(leaves_a);
    assign leaf_b_idx_o   = leaf_enc(leaves_b);

endmodule

`default_nettype wire

//--- src/kd_pkg.sv
// kd tree search shared definitions
`default_nettype none

package kd_pkg;

    // patch geometry
    localparam int KD_COMP_W  = 11;                    // one component, also dim and median
    localparam int KD_COMPS   = 5;                     // components per patch
    localparam int KD_PATCH_W = KD_COMPS * KD_COMP_W;  // component 0 sits in the low bits

    // node word, dimension above median
    localparam int KD_NODE_W = 2 * KD_COMP_W;

    // deepest tree the core can be built for
    // leaf index and node address are both this wide
    localparam int KD_MAX_DEPTH = 6;

    // tree view of a node word
    typedef struct packed {
        logic [KD_COMP_W-1:0] dim;     // split dimension, >= KD_COMPS picks component 0
        logic [KD_COMP_W-1:0] median;  // split value
    } node_tree_t;

    // bus view, half 0 = median, half 1 = dimension
    typedef logic [1:0][KD_NODE_W/2-1:0] node_halves_t;

    // one stored node, decoded by the search path as tree and by the bus as halves
    typedef union packed {
        node_tree_t   tree;
        node_halves_t half;
    } node_word_t;

endpackage

`default_nettype wire

//--- src/kd_search_top.sv
// kd tree search core top level
`default_nettype none

module kd_search_top #(
    parameter int          TREE_DEPTH = 6,
    parameter logic [31:0] WB_BASE    = 32'h0000_0300
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_mode_i,
    input  logic                            load_en_i,
    input  logic                            sender_en_i,
    input  kd_pkg::node_word_t              sender_data_i,
    input  logic                            wbs_cyc_i,
    input  logic                            wbs_stb_i,
    input  logic                            wbs_we_i,
    input  logic [3:0]                      wbs_sel_i,
    input  logic [31:0]                     wbs_adr_i,
    input  logic [31:0]                     wbs_dat_i,
    output logic                            wbs_ack_o,
    output logic [31:0]                     wbs_dat_o,
    input  logic                            patch_a_valid_i,
    input  logic [kd_pkg::KD_PATCH_W-1:0]   patch_a_i,
    input  logic                            patch_b_valid_i,
    input  logic [kd_pkg::KD_PATCH_W-1:0]   patch_b_i,
    output logic                            leaf_a_valid_o,
    output logic [kd_pkg::KD_MAX_DEPTH-1:0] leaf_a_idx_o,
    output logic                            leaf_b_valid_o,
    output logic [kd_pkg::KD_MAX_DEPTH-1:0] leaf_b_idx_o
);
    import kd_pkg::*;

    logic                    wb_wen;       // commit pulse
    logic [KD_MAX_DEPTH-1:0] wb_node_adr;
    node_word_t              wb_wdata;
    node_word_t              wb_rdata;     // combinational node read

    kd_wb_port #(
        .WB_BASE (WB_BASE)
    ) i_wb_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_mode_i    (cfg_mode_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_sel_i     (wbs_sel_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .wb_wen_o      (wb_wen),
        .wb_node_adr_o (wb_node_adr),
        .wb_wdata_o    (wb_wdata),
        .wb_rdata_i    (wb_rdata)
    );

    kd_node_tree #(
        .TREE_DEPTH (TREE_DEPTH)
    ) i_node_tree (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_mode_i      (cfg_mode_i),
        .load_en_i       (load_en_i),
        .sender_en_i     (sender_en_i),
        .sender_data_i   (sender_data_i),
        .wb_wen_i        (wb_wen),
        .wb_node_adr_i   (wb_node_adr),
        .wb_wdata_i      (wb_wdata),
        .wb_rdata_o      (wb_rdata),
        .patch_a_valid_i (patch_a_valid_i),
        .patch_a_i       (patch_a_i),
        .patch_b_valid_i (patch_b_valid_i),
        .patch_b_i       (patch_b_i),
        .leaf_a_valid_o  (leaf_a_valid_o),
        .leaf_a_idx_o    (leaf_a_idx_o),
        .leaf_b_valid_o  (leaf_b_valid_o),
        .leaf_b_idx_o    (leaf_b_idx_o)
    );

endmodule

`default_nettype wire

//--- src/kd_wb_port.sv
// wishbone slave for node words
`default_nettype none

module kd_wb_port #(
    parameter logic [31:0] WB_BASE = 32'h0000_0300
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_mode_i,   // port only answers in config mode
    input  logic                            wbs_cyc_i,
    input  logic                            wbs_stb_i,
    input  logic                            wbs_we_i,
    input  logic [3:0]                      wbs_sel_i,    // full words only, lanes not decoded
    input  logic [31:0]                     wbs_adr_i,
    input  logic [31:0]                     wbs_dat_i,    // bit 11 = half select
    output logic                            wbs_ack_o,
    output logic [31:0]                     wbs_dat_o,
    output logic                            wb_wen_o,     // commit pulse, with ack
    output logic [kd_pkg::KD_MAX_DEPTH-1:0] wb_node_adr_o,
    output kd_pkg::node_word_t              wb_wdata_o,
    input  kd_pkg::node_word_t              wb_rdata_i
);
    import kd_pkg::*;

    logic [31:0]          rel_adr;   // offset from base
    logic                 req;       // live request
    logic                 req_q;     // req last cycle
    logic                 accept;    // first cycle of stb
    logic                 half_sel;
    logic                 ack_q;
    logic                 wen_q;
    logic [KD_COMP_W-1:0] lo_q;      // pending half 0
    node_word_t           wdata_q;   // word being committed
    logic [KD_COMP_W-1:0] rd_q;      // returned half

    // word aligned node address
    assign rel_adr       = wbs_adr_i - WB_BASE;
    assign wb_node_adr_o = rel_adr[KD_MAX_DEPTH+1:2];

    assign req      = cfg_mode_i & wbs_cyc_i & wbs_stb_i;
    assign accept   = req & ~req_q;         // one ack per stb assertion
    assign half_sel = wbs_dat_i[KD_COMP_W];

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
            wen_q <= 1'b0;
            lo_q  <= '0;
        end else begin
            req_q <= req;
            ack_q <= accept;
            wen_q <= accept & wbs_we_i & half_sel;  // half 1 commits
            if (accept && wbs_we_i && !half_sel) begin
                lo_q <= wbs_dat_i[KD_COMP_W-1:0];  // hold until half 1
            end
        end
    end

    // payload, sampled with the request
    always_ff @(posedge clk) begin
        if (accept) begin
            wdata_q.half[1] <= wbs_dat_i[KD_COMP_W-1:0];
            wdata_q.half[0] <= lo_q;
            rd_q            <= wb_rdata_i.half[half_sel];
        end
    end

    assign wbs_ack_o  = ack_q;
    assign wb_wen_o   = wen_q;
    assign wb_wdata_o = wdata_q;
    assign wbs_dat_o  = {{(32-KD_COMP_W){1'b0}}, rd_q};  // zero extended half

endmodule

`default_nettype wire

//--- verif/kd_tb_model.svh
// kd tree reference model
`ifndef KD_TB_MODEL_SVH
`define KD_TB_MODEL_SVH

    // expected node words in heap order, {dim, median}
    logic [KD_NODE_W-1:0] model_node [NODES];

    // component picked by a split dimension
    function automatic logic [KD_COMP_W-1:0] model_comp(
        input logic [KD_PATCH_W-1:0] patch,
        input logic [KD_COMP_W-1:0]  dim
    );
        int d;
        d = (dim < KD_COMPS) ? int'(dim) : 0;  // dims past the patch use component 0
        return patch[d*KD_COMP_W +: KD_COMP_W];
    endfunction

    // walk root to leaf, one path bit per level, root branch ends up as MSB
    function automatic logic [KD_MAX_DEPTH-1:0] model_leaf(input logic [KD_PATCH_W-1:0] patch);
        int                      n;
        logic                    go_right;
        logic [KD_MAX_DEPTH-1:0] path;
        n    = 0;
        path = '0;
        for (int lvl = 0; lvl < DEPTH; lvl++) begin
            go_right = model_comp(patch, model_node[n][KD_NODE_W-1:KD_COMP_W])
                       >= model_node[n][KD_COMP_W-1:0];  // ties go right
            path     = {path[KD_MAX_DEPTH-2:0], go_right};
            n        = 2*n + (go_right ? 2 : 1);         // heap children
        end
        return path;
    endfunction

`endif

//--- verif/tb_kd_search.sv
// kd tree search testbench
`default_nettype none

module tb_kd_search;
    timeunit 1ns;
    timeprecision 1ps;
    import kd_pkg::*;

    localparam int          DEPTH         = 6;
    localparam int          NODES         = 2**DEPTH - 1;
    localparam logic [31:0] WB_BASE       = 32'h0000_0300;
    localparam int          ACCESS_CYCLES = 3;  // per bus access
    localparam int          TEST_CYCLES   = 5 + (DEPTH + 3)          // reset, first search
                                          + 4 * NODES * ACCESS_CYCLES  // bus write and read
                                          + 2 * NODES + 2 * NODES * ACCESS_CYCLES  // stream
                                          + 8 * (DEPTH + 2)          // single searches
                                          + 40 + DEPTH + 2;          // dual lane burst
    localparam int          TIMEOUT       = TEST_CYCLES + 500;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    cfg_mode_i;
    logic                    load_en_i;
    logic                    sender_en_i;
    node_word_t              sender_data_i;
    logic                    wbs_cyc_i;
    logic                    wbs_stb_i;
    logic                    wbs_we_i;
    logic [3:0]              wbs_sel_i;
    logic [31:0]             wbs_adr_i;
    logic [31:0]             wbs_dat_i;
    logic                    wbs_ack_o;
    logic [31:0]             wbs_dat_o;
    logic                    patch_a_valid_i;
    logic [KD_PATCH_W-1:0]   patch_a_i;
    logic                    patch_b_valid_i;
    logic [KD_PATCH_W-1:0]   patch_b_i;
    logic                    leaf_a_valid_o;
    logic [KD_MAX_DEPTH-1:0] leaf_a_idx_o;
    logic                    leaf_b_valid_o;
    logic [KD_MAX_DEPTH-1:0] leaf_b_idx_o;
    int                      cycles = 0;

    `include "kd_tb_model.svh"

    kd_search_top #(
        .TREE_DEPTH (DEPTH),
        .WB_BASE    (WB_BASE)
    ) i_kd_search_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_mode_i      (cfg_mode_i),
        .load_en_i       (load_en_i),
        .sender_en_i     (sender_en_i),
        .sender_data_i   (sender_data_i),
        .wbs_cyc_i       (wbs_cyc_i),
        .wbs_stb_i       (wbs_stb_i),
        .wbs_we_i        (wbs_we_i),
        .wbs_sel_i       (wbs_sel_i),
        .wbs_adr_i       (wbs_adr_i),
        .wbs_dat_i       (wbs_dat_i),
        .wbs_ack_o       (wbs_ack_o),
        .wbs_dat_o       (wbs_dat_o),
        .patch_a_valid_i (patch_a_valid_i),
        .patch_a_i       (patch_a_i),
        .patch_b_valid_i (patch_b_valid_i),
        .patch_b_i       (patch_b_i),
        .leaf_a_valid_o  (leaf_a_valid_o),
        .leaf_a_idx_o    (leaf_a_idx_o),
        .leaf_b_valid_o  (leaf_b_valid_o),
        .leaf_b_idx_o    (leaf_b_idx_o)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            report_failure("timeout because the run went past its cycle limit");
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // land just past the next edge, inputs change here and outputs are settled
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [KD_PATCH_W-1:0] rand_patch();
        return KD_PATCH_W'({$urandom, $urandom});
    endfunction

    // dims 0..6 so out-of-range dims show up too
    function automatic logic [KD_NODE_W-1:0] rand_node();
        return {KD_COMP_W'($urandom % 7), KD_COMP_W'($urandom)};
    endfunction

    // one classic access, stb held one cycle past ack so a second ack would show
    task automatic bus_access(
        input  logic                 we,
        input  int                   node,
        input  logic                 half,
        input  logic [KD_COMP_W-1:0] wdata,
        output logic [31:0]          rdata
    );
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = WB_BASE + 32'(node * 4);  // word aligned nodes
        wbs_dat_i = {20'h0, half, wdata};     // bit 11 picks the half
        do begin
            step();
        end while (!wbs_ack_o);
        rdata = wbs_dat_o;
        step();
        check_val("wbs_ack_o", wbs_ack_o, 0);  // single ack per stb
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        step();
    endtask

    task automatic write_node(input int node, input logic [KD_NODE_W-1:0] word);
        logic [31:0] rd;
        bus_access(1'b1, node, 1'b0, word[KD_COMP_W-1:0], rd);          // median, held
        bus_access(1'b1, node, 1'b1, word[KD_NODE_W-1:KD_COMP_W], rd);  // dim, commits
        model_node[node] = word;
    endtask

    task automatic read_check(input int node);
        logic [31:0] rd;
        bus_access(1'b0, node, 1'b0, '0, rd);
        check_val("wbs_dat_o", rd, 32'(model_node[node][KD_COMP_W-1:0]));
        bus_access(1'b0, node, 1'b1, '0, rd);
        check_val("wbs_dat_o", rd, 32'(model_node[node][KD_NODE_W-1:KD_COMP_W]));
    endtask

    // one patch per lane, leaf due exactly DEPTH cycles after the sampling edge
    task automatic search_one(input logic [KD_PATCH_W-1:0] pa, input logic [KD_PATCH_W-1:0] pb);
        int lat;
        patch_a_valid_i = 1'b1;
        patch_a_i       = pa;
        patch_b_valid_i = 1'b1;
        patch_b_i       = pb;
        step();  // sampled on this edge
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
        lat = 0;
        while (!leaf_a_valid_o) begin
            step();
            lat++;
        end
        assert (lat == DEPTH)
        else report_failure($sformatf("lane a leaf came after %0d cycles instead of %0d",
                                      lat, DEPTH));
        check_val("leaf_b_valid_o", leaf_b_valid_o, 1);
        check_val("leaf_a_idx_o", leaf_a_idx_o, model_leaf(pa));
        check_val("leaf_b_idx_o", leaf_b_idx_o, model_leaf(pb));
        step();
        check_val("leaf_a_valid_o", leaf_a_valid_o, 0);  // one pulse per patch
    endtask

    task automatic test_reset_state();
        for (int n = 0; n < NODES; n++) begin
            model_node[n] = '0;
        end
        check_val("wbs_ack_o", wbs_ack_o, 0);
        check_val("leaf_a_valid_o", leaf_a_valid_o, 0);
        check_val("leaf_b_valid_o", leaf_b_valid_o, 0);
        search_one(rand_patch(), rand_patch());  // all-zero tree, always right
    endtask

    task automatic test_bus_rw();
        cfg_mode_i = 1'b1;
        for (int n = 0; n < NODES; n++) begin
            write_node(n, KD_NODE_W'($urandom));
        end
        for (int n = 0; n < NODES; n++) begin
            read_check(n);
        end
        cfg_mode_i = 1'b0;
    endtask

    task automatic test_stream_load();
        logic [KD_NODE_W-1:0] w;
        int                   gap;
        for (int n = 0; n < NODES; n++) begin
            w   = rand_node();
            gap = $urandom % 4;
            if (gap != 3) begin
                // idle sender, bus mode or load phase off, nothing gets stored
                sender_en_i   = (gap != 0);
                cfg_mode_i    = (gap == 1);
                load_en_i     = (gap != 2);
                sender_data_i = ~w;
                step();
            end
            sender_en_i   = 1'b1;
            cfg_mode_i    = 1'b0;
            load_en_i     = 1'b1;
            sender_data_i = w;
            model_node[n] = w;  // level order
            step();
        end
        sender_en_i = 1'b0;
        load_en_i   = 1'b0;
        cfg_mode_i  = 1'b1;
        for (int n = 0; n < NODES; n++) begin
            read_check(n);
        end
        cfg_mode_i = 1'b0;
    endtask

    task automatic test_single_search();
        repeat (8) begin
            search_one(rand_patch(), rand_patch());
        end
    endtask

    // back to back patches on both lanes, results in order
    task automatic test_dual_lane();
        logic [KD_MAX_DEPTH-1:0] exp_a [$];
        logic [KD_MAX_DEPTH-1:0] exp_b [$];
        logic [KD_PATCH_W-1:0]   pa;
        logic [KD_PATCH_W-1:0]   pb;
        for (int cyc = 0; cyc < 40 + DEPTH + 2; cyc++) begin
            pa              = rand_patch();
            pb              = rand_patch();
            patch_a_valid_i = (cyc < 40);
            patch_b_valid_i = (cyc < 40);
            patch_a_i       = pa;
            patch_b_i       = pb;
            if (cyc < 40) begin
                exp_a.push_back(model_leaf(pa));
                exp_b.push_back(model_leaf(pb));
            end
            step();
            if (leaf_a_valid_o) begin
                assert (exp_a.size() > 0)
                else report_failure("lane a gave a leaf with no patch outstanding");
                check_val("leaf_a_idx_o", leaf_a_idx_o, exp_a.pop_front());
            end
            if (leaf_b_valid_o) begin
                assert (exp_b.size() > 0)
                else report_failure("lane b gave a leaf with no patch outstanding");
                check_val("leaf_b_idx_o", leaf_b_idx_o, exp_b.pop_front());
            end
        end
        assert (exp_a.size() == 0 && exp_b.size() == 0)
        else report_failure("some patches never produced a leaf");
    endtask

    initial begin
        void'($urandom(32'h2f55_e1c3));
        rst_n           = 1'b0;
        cfg_mode_i      = 1'b0;
        load_en_i       = 1'b0;
        sender_en_i     = 1'b0;
        sender_data_i   = '0;
        wbs_cyc_i       = 1'b0;
        wbs_stb_i       = 1'b0;
        wbs_we_i        = 1'b0;
        wbs_sel_i       = 4'hf;  // full words
        wbs_adr_i       = '0;
        wbs_dat_i       = '0;
        patch_a_valid_i = 1'b0;
        patch_a_i       = '0;
        patch_b_valid_i = 1'b0;
        patch_b_i       = '0;
        repeat (5) begin
            step();
        end
        rst_n = 1'b1;
        test_reset_state();
        test_bus_rw();
        test_stream_load();
        test_single_search();
        test_dual_lane();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
